//--- project.f
verilog/bpu_pkg.sv
verilog/btb_bank_ram.sv
verilog/btb.sv
verilog/btb_update_port.sv
verilog/btb_hit_check.sv
verilog/bpu_top.sv
sim/bpu_tb.sv

//--- sim/bpu_tb.sv
`timescale 1ns/1ns

module bpu_tb;

    localparam int TIMEOUT_NS = 3000 * 12 * 4;

    typedef enum {STEP_NONE, STEP_ACCEPT, STEP_IDLE, STEP_STALL} step_t;

    logic                 clk;
    logic                 arst_n;
    logic                 stall;
    logic                 lookup_valid;
    logic [31:0]          lookup_pc;
    logic                 upd_req;
    bpu_pkg::btb_update_t upd_info;
    logic                 upd_ack;
    logic                 pred_valid;
    bpu_pkg::bpu_pred_t   pred;

    integer               seed;
    int                   error_count;
    bpu_pkg::btb_entry_t  ref_mem [4][64];
    logic [31:0]          accepted_pcs [$];
    step_t                step_kind;
    logic                 held_valid;
    bpu_pkg::bpu_pred_t   held_pred;

    bpu_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .upd_req      (upd_req),
        .upd_info     (upd_info),
        .upd_ack      (upd_ack),
        .pred_valid   (pred_valid),
        .pred         (pred)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string line);
        error_count++;
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_error($sformatf("FAIL %0t ns: %s", $time, msg));
    endtask

    // The bank comes from PC bits 3..2, the set from 9..4 and the tag from 17..10.
    function automatic bpu_pkg::bpu_pred_t ref_pred(input logic [31:0] pc);
        bpu_pkg::btb_entry_t e;
        bpu_pkg::bpu_pred_t  p;
        e         = ref_mem[pc[3:2]][pc[9:4]];
        p.pc      = pc;
        p.hit     = e.valid && (e.tag == pc[17:10]);
        p.target  = '0;
        p.br_type = bpu_pkg::BR_COND;
        if (p.hit) begin
            p.target  = {e.target, 2'b00};
            p.br_type = e.br_type;
        end
        return p;
    endfunction

    function automatic bpu_pkg::btb_update_t make_update(input logic [31:0] pc,
            input logic [31:0] target, input bpu_pkg::br_type_t kind);
        bpu_pkg::btb_update_t u;
        u.start_addr    = pc;
        u.entry.valid   = 1'b1;
        u.entry.tag     = pc[17:10];
        u.entry.target  = target[31:2];
        u.entry.br_type = kind;
        return u;
    endfunction

    task automatic check_pred(input bpu_pkg::bpu_pred_t got, input bpu_pkg::bpu_pred_t exp);
        if (got.pc !== exp.pc) begin
            report_mismatch($sformatf("pred.pc is %h, expected %h", got.pc, exp.pc));
        end else if (got.hit !== exp.hit) begin
            report_mismatch($sformatf("pred.hit is %b, expected %b for pc %h",
                got.hit, exp.hit, exp.pc));
        end else if (got.target !== exp.target) begin
            report_mismatch($sformatf("pred.target is %h, expected %h for pc %h",
                got.target, exp.target, exp.pc));
        end else if (got.br_type !== exp.br_type) begin
            report_mismatch($sformatf("pred.br_type is %0d, expected %0d for pc %h",
                got.br_type, exp.br_type, exp.pc));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("pred_valid is %b, expected %b", got, exp));
        end
    endtask

    task automatic check_ack_state(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("upd_ack is %b, expected %b", got, exp));
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            lookup_valid <= 1'b0;
            stall        <= 1'b0;
        end
    endtask

    // Presents pc with stall held for stall_cycles edges; accepted on the edge after.
    task automatic do_lookup(input logic [31:0] pc, input int stall_cycles);
        int i;
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        stall        <= (stall_cycles > 0);
        for (i = 0; i < stall_cycles; i++) begin
            @(posedge clk);
            if (i == stall_cycles - 1) begin
                stall <= 1'b0;
            end
        end
    endtask

    // Four-phase handshake. extra_hold keeps upd_req high after upd_ack rises.
    task automatic do_update(input bpu_pkg::btb_update_t info, input int extra_hold);
        int waited;
        int i;
        @(posedge clk);
        lookup_valid <= 1'b0;
        stall        <= 1'b0;
        upd_req      <= 1'b1;
        upd_info     <= info;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                stop_with_error("Handshake stuck: upd_ack did not rise within 20 cycles");
            end
        end while (upd_ack !== 1'b1);
        ref_mem[info.start_addr[3:2]][info.start_addr[9:4]] = info.entry;
        for (i = 0; i < extra_hold; i++) begin
            @(negedge clk);
            check_ack_state(upd_ack, 1'b1);
        end
        @(posedge clk);
        upd_req <= 1'b0;
        @(negedge clk);
        check_ack_state(upd_ack, 1'b1);
        @(negedge clk);
        check_ack_state(upd_ack, 1'b0);
    endtask

    function automatic logic [31:0] random_pc();
        logic [7:0] tag;
        logic [5:0] set;
        logic [1:0] bank;
        tag  = 8'h20 + ($random(seed) & 1);
        set  = $random(seed) & 6'h03;
        bank = $random(seed);
        return {14'h0, tag, set, bank, 2'b00};
    endfunction

    // Outputs are compared mid-cycle, then the inputs the next edge will take are noted.
    always @(negedge clk) begin : compare_proc
        logic [31:0] pc;
        case (step_kind)
            STEP_ACCEPT: begin
                pc = accepted_pcs.pop_front();
                check_valid(pred_valid, 1'b1);
                check_pred(pred, ref_pred(pc));
            end
            STEP_IDLE: check_valid(pred_valid, 1'b0);
            STEP_STALL: begin
                check_valid(pred_valid, held_valid);
                check_pred(pred, held_pred);
            end
            default: ;
        endcase
        held_valid = pred_valid;
        held_pred  = pred;
        if (!arst_n) begin
            step_kind = STEP_NONE;
        end else if (stall) begin
            step_kind = STEP_STALL;
        end else if (lookup_valid) begin
            step_kind = STEP_ACCEPT;
            accepted_pcs.push_back(lookup_pc);
        end else begin
            step_kind = STEP_IDLE;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_with_error($sformatf("Timeout: the test did not finish within %0d ns", TIMEOUT_NS));
    end

    initial begin : main
        int i;
        clk          = 1'b0;
        seed         = 32'hd8d9;
        error_count  = 0;
        step_kind    = STEP_NONE;
        arst_n       <= 1'b0;
        stall        <= 1'b0;
        lookup_valid <= 1'b0;
        lookup_pc    <= '0;
        upd_req      <= 1'b0;
        upd_info     <= '0;
        for (i = 0; i < 256; i++) begin
            ref_mem[i / 64][i % 64] = '0;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        idle(2);

        do_lookup(32'h0000_0100, 0);
        do_lookup(32'h0000_2040, 0);
        idle(2);

        do_update(make_update(32'h0000_1234, 32'h8000_0040, bpu_pkg::BR_CALL), 0);
        do_lookup(32'h0000_1234, 0);
        do_lookup(32'h0000_1634, 0);
        do_update(make_update(32'h0000_1634, 32'h9000_0100, bpu_pkg::BR_JUMP), 0);
        do_lookup(32'h0000_1234, 0);
        do_lookup(32'h0000_1634, 0);

        for (i = 0; i < 4; i++) begin
            do_update(make_update(32'h0000_4000 + 4 * i, 32'h0000_5000 + 16 * i,
                bpu_pkg::br_type_t'(i)), 0);
        end
        for (i = 0; i < 4; i++) begin
            do_lookup(32'h0000_4000 + 4 * i, 0);
        end

        // Stall with a valid prediction on the output, then an ack held for extra cycles.
        do_lookup(32'h0000_4000, 0);
        do_lookup(32'h0000_4004, 4);
        do_lookup(32'h0000_4008, 0);
        idle(1);
        do_update(make_update(32'h0000_6000, 32'h0000_7000, bpu_pkg::BR_RET), 3);
        do_lookup(32'h0000_6000, 0);

        for (i = 0; i < 2000; i++) begin
            if ($unsigned($random(seed)) % 3 == 0) begin
                do_update(make_update(random_pc(), $random(seed),
                    bpu_pkg::br_type_t'($random(seed) & 3)), 0);
            end else begin
                do_lookup(random_pc(), ($unsigned($random(seed)) % 8 == 0) ? 2 : 0);
            end
        end
        idle(3);

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/bpu_top.sv
`timescale 1ns/1ns

module bpu_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         stall,
    input  logic                         lookup_valid,
    input  logic [bpu_pkg::PC_WIDTH-1:0] lookup_pc,
    input  logic                         upd_req,
    input  bpu_pkg::btb_update_t         upd_info,
    output logic                         upd_ack,
    output logic                         pred_valid,
    output bpu_pkg::bpu_pred_t           pred
);

    logic                 wr_en;
    bpu_pkg::btb_update_t wr_info;
    bpu_pkg::btb_entry_t  rd_entry;

    btb_update_port u_update_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .upd_req  (upd_req),
        .upd_info (upd_info),
        .upd_ack  (upd_ack),
        .wr_en    (wr_en),
        .wr_info  (wr_info)
    );

    btb u_btb (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .lookup_pc    (lookup_pc),
        .lookup_valid (lookup_valid),
        .wr_en        (wr_en),
        .wr_info      (wr_info),
        .rd_entry     (rd_entry)
    );

    btb_hit_check u_hit_check (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .rd_entry     (rd_entry),
        .pred_valid   (pred_valid),
        .pred         (pred)
    );

endmodule

//--- verilog/btb_hit_check.sv
`timescale 1ns/1ns

module btb_hit_check (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         stall,
    input  logic                         lookup_valid,
    input  logic [bpu_pkg::PC_WIDTH-1:0] lookup_pc,
    input  bpu_pkg::btb_entry_t          rd_entry,
    output logic                         pred_valid,
    output bpu_pkg::bpu_pred_t           pred
);

    logic                          s2_valid_q;
    logic [bpu_pkg::PC_WIDTH-1:0]  s2_pc_q;
    logic [bpu_pkg::TAG_WIDTH-1:0] s2_tag;
    logic                          hit;

    // Stage 2 runs alongside the bank read and freezes with it.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid_q <= 1'b0;
        end else if (!stall) begin
            s2_valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s2_pc_q <= lookup_pc;
        end
    end

    assign s2_tag = s2_pc_q[bpu_pkg::TAG_LSB +: bpu_pkg::TAG_WIDTH];
    assign hit    = rd_entry.valid && (rd_entry.tag == s2_tag);

    assign pred_valid = s2_valid_q;

    // A miss reports zero target and BR_COND.
    always_comb begin
        pred.pc      = s2_pc_q;
        pred.hit     = hit;
        pred.target  = '0;
        pred.br_type = bpu_pkg::BR_COND;
        if (hit) begin
            pred.target  = {rd_entry.target, 2'b00};
            pred.br_type = rd_entry.br_type;
        end
    end

endmodule

//--- verilog/btb_update_port.sv
`timescale 1ns/1ns

module btb_update_port (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 upd_req,
    input  bpu_pkg::btb_update_t upd_info,
    output logic                 upd_ack,
    output logic                 wr_en,
    output bpu_pkg::btb_update_t wr_info
);

    bpu_pkg::upd_state_t state_q;
    bpu_pkg::upd_state_t state_d;
    logic                accept;

    assign accept = (state_q == bpu_pkg::UPD_IDLE) && upd_req;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bpu_pkg::UPD_IDLE: begin
                if (upd_req) begin
                    state_d = bpu_pkg::UPD_WRITE;
                end
            end
            bpu_pkg::UPD_WRITE: begin
                state_d = bpu_pkg::UPD_ACK;
            end
            bpu_pkg::UPD_ACK: begin
                // Hold the ack until the producer drops its request.
                if (!upd_req) begin
                    state_d = bpu_pkg::UPD_IDLE;
                end
            end
            default: begin
                state_d = bpu_pkg::UPD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= bpu_pkg::UPD_IDLE;
            wr_en   <= 1'b0;
        end else begin
            state_q <= state_d;
            wr_en   <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_info <= upd_info;
        end
    end

    assign upd_ack = (state_q == bpu_pkg::UPD_ACK);

    assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (state_q == bpu_pkg::UPD_WRITE))
        else $error("btb_update_port: write pulse outside UPD_WRITE");

    // Producer side of the handshake.
    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(upd_req) |-> $past(upd_ack))
        else $error("btb_update_port: upd_req dropped before upd_ack");

endmodule

//--- verilog/btb.sv
`timescale 1ns/1ns

module btb (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         stall,
    input  logic [bpu_pkg::PC_WIDTH-1:0] lookup_pc,
    input  logic                         lookup_valid,
    input  logic                         wr_en,
    input  bpu_pkg::btb_update_t         wr_info,
    output bpu_pkg::btb_entry_t          rd_entry
);

    logic [bpu_pkg::SET_WIDTH-1:0]               rd_set;
    logic [bpu_pkg::SET_WIDTH-1:0]               wr_set;
    logic [bpu_pkg::WAY_WIDTH-1:0]               rd_bank;
    logic [bpu_pkg::WAY_WIDTH-1:0]               wr_bank;
    logic [bpu_pkg::WAY_WIDTH-1:0]               s2_bank_q;
    logic [bpu_pkg::BTB_WAY-1:0]                 bank_en;
    logic [bpu_pkg::BTB_WAY-1:0]                 bank_we;
    bpu_pkg::btb_entry_t [bpu_pkg::BTB_WAY-1:0]  bank_rdata;

    assign rd_set  = lookup_pc[bpu_pkg::SET_LSB +: bpu_pkg::SET_WIDTH];
    assign rd_bank = lookup_pc[bpu_pkg::WAY_LSB +: bpu_pkg::WAY_WIDTH];
    assign wr_set  = wr_info.start_addr[bpu_pkg::SET_LSB +: bpu_pkg::SET_WIDTH];
    assign wr_bank = wr_info.start_addr[bpu_pkg::WAY_LSB +: bpu_pkg::WAY_WIDTH];

    // Bank decode. Only the addressed bank reads, and only on an accepted lookup.
    always_comb begin
        bank_en          = '0;
        bank_we          = '0;
        bank_en[rd_bank] = lookup_valid & ~stall;
        bank_we[wr_bank] = wr_en;
    end

    for (genvar i = 0; i < bpu_pkg::BTB_WAY; i++) begin : g_bank
        btb_bank_ram u_bank (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (bank_en[i]),
            .we     (bank_we[i]),
            .waddr  (wr_set),
            .raddr  (rd_set),
            .wdata  (wr_info.entry),
            .rdata  (bank_rdata[i])
        );
    end

    // Stage-2 bank select follows the read, so it must freeze with the banks.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_bank_q <= '0;
        end else if (!stall) begin
            s2_bank_q <= rd_bank;
        end
    end

    assign rd_entry = bank_rdata[s2_bank_q];

    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(bank_we))
        else $error("btb: more than one bank write enable high");

endmodule

//--- verilog/btb_bank_ram.sv
`timescale 1ns/1ns

module btb_bank_ram (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          en,
    input  logic                          we,
    input  logic [bpu_pkg::SET_WIDTH-1:0] waddr,
    input  logic [bpu_pkg::SET_WIDTH-1:0] raddr,
    input  bpu_pkg::btb_entry_t           wdata,
    output bpu_pkg::btb_entry_t           rdata
);

    logic [bpu_pkg::BTB_SET-1:0] valid_q;
    bpu_pkg::btb_entry_t         mem [bpu_pkg::BTB_SET];
    bpu_pkg::btb_entry_t         rd_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[waddr] <= wdata.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The valid bit comes from the resettable vector, the rest from storage.
    always_comb begin
        rd_word       = mem[raddr];
        rd_word.valid = valid_q[raddr];
    end

    // Read-first. A write to the same set in this cycle is seen on the next read.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= rd_word;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        en |-> !$isunknown(raddr))
        else $error("btb_bank_ram: unknown read address on an enabled read");

endmodule

//--- verilog/bpu_pkg.sv
package bpu_pkg;

    localparam int PC_WIDTH     = 32;
    localparam int BTB_WAY      = 4;
    localparam int WAY_WIDTH    = $clog2(BTB_WAY);
    localparam int BTB_SET      = 64;
    localparam int SET_WIDTH    = $clog2(BTB_SET);
    localparam int TAG_WIDTH    = 8;
    localparam int TARGET_WIDTH = PC_WIDTH - 2;

    // Field positions within a fetch PC. Bits 1..0 are the byte offset.
    localparam int WAY_LSB = 2;
    localparam int SET_LSB = WAY_LSB + WAY_WIDTH;
    localparam int TAG_LSB = SET_LSB + SET_WIDTH;

    typedef enum logic [1:0] {
        BR_COND = 2'b00,
        BR_JUMP = 2'b01,
        BR_CALL = 2'b10,
        BR_RET  = 2'b11
    } br_type_t;

    typedef enum logic [1:0] {
        UPD_IDLE  = 2'b00,
        UPD_WRITE = 2'b01,
        UPD_ACK   = 2'b10
    } upd_state_t;

    // One stored entry. The target is a word address.
    typedef struct packed {
        logic                    valid;
        logic [TAG_WIDTH-1:0]    tag;
        logic [TARGET_WIDTH-1:0] target;
        br_type_t                br_type;
    } btb_entry_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0] start_addr;
        btb_entry_t          entry;
    } btb_update_t;

    // Prediction for one fetch PC, target given as a byte address.
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                hit;
        logic [PC_WIDTH-1:0] target;
        br_type_t            br_type;
    } bpu_pred_t;

endpackage
